/* files.f */
mem_pkg.sv
burst_mem.sv
mem_arbiter.sv
frame_reader.sv
mem_tester.sv
mem_subsys.sv
tb_mem_subsys.sv

/* Makefile */
TOP := tb_mem_subsys
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: obj_dir/V$(TOP)

obj_dir/V$(TOP): files.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* tb_mem_subsys.sv */
module tb_mem_subsys import mem_pkg::*; ();

// One row per tester run
typedef struct packed {
	logic stream;
	logic verify_only;
	logic invert;
	logic exp_fail;
} row_t;

localparam int NROWS = 6;
// Pixels checked alone, then alongside each streaming row
localparam int PIXELS = 6 * FRAME_WORDS;
localparam int LIMIT_CYCLES = 200 * TEST_WORDS * NROWS + 100 * PIXELS;

logic clkSYS;
logic n_reset;
logic frame_en;
logic pix_rd;
logic test_start;
logic test_verify_only;
logic test_invert;
data_t pix_data;
logic pix_valid;
logic test_busy;
logic test_done;
logic test_fail;

row_t rows [0:NROWS - 1];
logic [31:0] rng;
int pix_count;

mem_subsys dut0 (
	.clkSYS(clkSYS),
	.n_reset(n_reset),
	.frame_en(frame_en),
	.pix_rd(pix_rd),
	.test_start(test_start),
	.test_verify_only(test_verify_only),
	.test_invert(test_invert),
	.pix_data(pix_data),
	.pix_valid(pix_valid),
	.test_busy(test_busy),
	.test_done(test_done),
	.test_fail(test_fail)
);

initial begin
	clkSYS = 1'b0;
	forever #2 clkSYS = ~clkSYS;
end

// Watchdog
initial begin
	repeat (LIMIT_CYCLES) @(posedge clkSYS);
	$display("*** FAILED ***");
	$fatal(1, "timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
end

function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// Inverted pattern, frame address wraps after FRAME_WORDS
function automatic data_t expected_pixel(input int k);
	addr_t a;
	data_t p;
	a = FRAME_BASE + addr_t'(k % FRAME_WORDS);
	p = data_t'(a) ^ PATTERN_KEY;
	return ~p;
endfunction

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("mismatch %s: got %h, expected %h", name, got, exp);
		$display("*** FAILED ***");
		$fatal(1, "%s has the wrong value", name);
	end
endtask

task automatic check_pixel(input string name, input data_t got, input data_t exp);
	if (got !== exp) begin
		$display("mismatch %s: got %h, expected %h", name, got, exp);
		$display("*** FAILED ***");
		$fatal(1, "%s has the wrong value", name);
	end
endtask

// Accepts n pixels under random stalls and checks them in order
task automatic accept_pixels(input int n);
	int got;
	logic take;
	got = 0;
	while (got < n) begin
		@(negedge clkSYS);
		rng = xorshift(rng);
		take = rng[1:0] != 2'b00;
		if (take && pix_valid) begin
			check_pixel($sformatf("pix_data[%0d]", pix_count), pix_data,
				expected_pixel(pix_count));
			pix_count++;
			got++;
		end
		pix_rd = take;
	end
	// Let the last accepted pixel pop before stalling
	@(negedge clkSYS);
	pix_rd = 1'b0;
endtask

// One tester run, start pulse then wait for done
task automatic run_tester(input row_t r);
	@(negedge clkSYS);
	test_verify_only = r.verify_only;
	test_invert = r.invert;
	test_start = 1'b1;
	@(negedge clkSYS);
	test_start = 1'b0;
	check_flag("test_busy", test_busy, 1'b1);
	// Sticky fail is cleared by start
	check_flag("test_fail", test_fail, 1'b0);
	while (!test_done)
		@(negedge clkSYS);
	check_flag("test_fail", test_fail, r.exp_fail);
	check_flag("test_busy", test_busy, 1'b0);
	@(negedge clkSYS);
	check_flag("test_done", test_done, 1'b0);
endtask

initial begin
	n_reset = 1'b0;
	frame_en = 1'b0;
	pix_rd = 1'b0;
	test_start = 1'b0;
	test_verify_only = 1'b0;
	test_invert = 1'b0;
	rng = 32'd35363;
	pix_count = 0;

	// stream, verify_only, invert, exp_fail
	rows[0] = '{1'b0, 1'b0, 1'b0, 1'b0};
	rows[1] = '{1'b0, 1'b1, 1'b0, 1'b0};
	rows[2] = '{1'b0, 1'b1, 1'b1, 1'b1};
	rows[3] = '{1'b0, 1'b0, 1'b1, 1'b0};
	rows[4] = '{1'b1, 1'b0, 1'b1, 1'b0};
	rows[5] = '{1'b1, 1'b1, 1'b1, 1'b0};

	repeat (2) @(posedge clkSYS);
	@(negedge clkSYS);
	n_reset = 1'b1;
	check_flag("pix_valid", pix_valid, 1'b0);
	check_flag("test_busy", test_busy, 1'b0);
	check_flag("test_done", test_done, 1'b0);
	check_flag("test_fail", test_fail, 1'b0);

	for (int i = 0; i < NROWS; i++) begin
		if (rows[i].stream && !frame_en) begin
			// Memory now holds the inverted pattern
			frame_en = 1'b1;
			accept_pixels(2 * FRAME_WORDS);
		end
		if (rows[i].stream) begin
			fork
				run_tester(rows[i]);
				accept_pixels(2 * FRAME_WORDS);
			join
		end else begin
			run_tester(rows[i]);
			check_flag("pix_valid", pix_valid, 1'b0);
		end
	end

	$display("*** PASSED ***");
	$finish;
end

endmodule

/* mem_subsys.sv */
module mem_subsys import mem_pkg::*; (
	input logic clkSYS,
	input logic n_reset,
	input logic frame_en,
	input logic pix_rd,
	input logic test_start,
	input logic test_verify_only,
	input logic test_invert,
	output data_t pix_data,
	output logic pix_valid,
	output logic test_busy,
	output logic test_done,
	output logic test_fail
);

// Frame reader side
logic fr_req, fr_ack, fr_rvalid;
addr_t fr_addr;
data_t fr_rdata;

// Tester side
logic ts_req, ts_wr, ts_ack, ts_rvalid;
addr_t ts_addr;
data_t ts_wdata, ts_rdata;

// Memory side
logic mem_req, mem_wr, mem_ack, rd_valid;
addr_t mem_addr;
data_t mem_wdata, rd_data;
id_t mem_id, rd_id;

burst_mem mem0 (.clkSYS(clkSYS), .n_reset(n_reset),
	.mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
	.mem_id(mem_id), .mem_ack(mem_ack),
	.rd_data(rd_data), .rd_id(rd_id), .rd_valid(rd_valid));

// Frame reader only reads
mem_arbiter arb0 (.clkSYS(clkSYS), .n_reset(n_reset),
	.fr_req(fr_req), .fr_wr(1'b0), .fr_addr(fr_addr), .fr_wdata('0),
	.fr_ack(fr_ack), .fr_rdata(fr_rdata), .fr_rvalid(fr_rvalid),
	.ts_req(ts_req), .ts_wr(ts_wr), .ts_addr(ts_addr), .ts_wdata(ts_wdata),
	.ts_ack(ts_ack), .ts_rdata(ts_rdata), .ts_rvalid(ts_rvalid),
	.mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
	.mem_id(mem_id), .mem_ack(mem_ack),
	.rd_data(rd_data), .rd_id(rd_id), .rd_valid(rd_valid));

frame_reader fr0 (.clkSYS(clkSYS), .n_reset(n_reset), .frame_en(frame_en),
	.req(fr_req), .addr(fr_addr), .ack(fr_ack), .rdata(fr_rdata), .rvalid(fr_rvalid),
	.pix_rd(pix_rd), .pix_data(pix_data), .pix_valid(pix_valid));

mem_tester ts0 (.clkSYS(clkSYS), .n_reset(n_reset), .start(test_start),
	.verify_only(test_verify_only), .invert(test_invert),
	.req(ts_req), .wr(ts_wr), .addr(ts_addr), .wdata(ts_wdata),
	.ack(ts_ack), .rdata(ts_rdata), .rvalid(ts_rvalid),
	.busy(test_busy), .done(test_done), .fail(test_fail));

endmodule

/* mem_tester.sv */
module mem_tester import mem_pkg::*; (
	input logic clkSYS,
	input logic n_reset,
	input logic start,
	input logic verify_only,
	input logic invert,
	output logic req,
	output logic wr,
	output addr_t addr,
	output data_t wdata,
	input logic ack,
	input data_t rdata,
	input logic rvalid,
	output logic busy,
	output logic done,
	output logic fail
);

typedef enum logic [1:0] {S_IDLE, S_WR, S_RD, S_RWAIT} state_t;

state_t state;
logic inv;
logic [BURST_CW - 1:0] rcnt;
data_t exp_word;

function automatic data_t pattern(input addr_t a, input logic flip);
	data_t p;
	p = data_t'(a) ^ data_t'(PATTERN_KEY);
	return flip ? ~p : p;
endfunction

assign wdata = pattern(addr, inv);
// Expected word for the current burst position
assign exp_word = pattern(addr + addr_t'(rcnt), inv);

always_ff @(posedge clkSYS, negedge n_reset)
	if (!n_reset) begin
		state <= S_IDLE;
		req <= 1'b0;
		wr <= 1'b0;
		addr <= TEST_BASE;
		inv <= 1'b0;
		rcnt <= '0;
		busy <= 1'b0;
		done <= 1'b0;
		fail <= 1'b0;
	end else begin
		done <= 1'b0;
		case (state)
			S_IDLE:
				if (start) begin
					busy <= 1'b1;
					fail <= 1'b0;
					inv <= invert;
					addr <= TEST_BASE;
					rcnt <= '0;
					state <= verify_only ? S_RD : S_WR;
				end
			S_WR:
				if (ack) begin
					req <= 1'b0;
					if (addr == TEST_BASE + addr_t'(TEST_WORDS - 1)) begin
						addr <= TEST_BASE;
						state <= S_RD;
					end else begin
						addr <= addr + 1'b1;
					end
				end else if (!req) begin
					req <= 1'b1;
					wr <= 1'b1;
				end
			S_RD:
				if (ack) begin
					req <= 1'b0;
					state <= S_RWAIT;
				end else if (!req) begin
					req <= 1'b1;
					wr <= 1'b0;
				end
			S_RWAIT:
				if (rvalid) begin
					// Sticky until the next start
					if (rdata != exp_word)
						fail <= 1'b1;
					rcnt <= rcnt + 1'b1;
					if (rcnt == BURST_CW'(BURST - 1)) begin
						rcnt <= '0;
						if (addr == TEST_BASE + addr_t'(TEST_WORDS - BURST)) begin
							busy <= 1'b0;
							done <= 1'b1;
							state <= S_IDLE;
						end else begin
							addr <= addr + addr_t'(BURST);
							state <= S_RD;
						end
					end
				end
			default: state <= S_IDLE;
		endcase
	end

endmodule

/* frame_reader.sv */
module frame_reader import mem_pkg::*; (
	input logic clkSYS,
	input logic n_reset,
	input logic frame_en,
	output logic req,
	output addr_t addr,
	input logic ack,
	input data_t rdata,
	input logic rvalid,
	input logic pix_rd,
	output data_t pix_data,
	output logic pix_valid
);

data_t fifo [0:FIFO_DEPTH - 1];
logic [FIFO_AW - 1:0] wr_ptr;
logic [FIFO_AW - 1:0] rd_ptr;
logic [FIFO_AW:0] level;
logic [BURST_CW - 1:0] inflight;
logic push;
logic pop;
logic room;

assign push = rvalid;
assign pop = pix_rd && pix_valid;
assign pix_valid = level != '0;
assign pix_data = fifo[rd_ptr];

// Space for a full burst and nothing still on its way
assign room = level <= (FIFO_AW + 1)'(FIFO_DEPTH - BURST) && inflight == '0;

always_ff @(posedge clkSYS, negedge n_reset)
	if (!n_reset) begin
		req <= 1'b0;
		addr <= FRAME_BASE;
		inflight <= '0;
		wr_ptr <= '0;
		rd_ptr <= '0;
		level <= '0;
	end else begin
		if (ack) begin
			req <= 1'b0;
			if (addr == FRAME_BASE + addr_t'(FRAME_WORDS - BURST))
				addr <= FRAME_BASE;
			else
				addr <= addr + addr_t'(BURST);
		end else if (!req && frame_en && room) begin
			req <= 1'b1;
			inflight <= BURST_CW'(BURST);
		end
		if (push) begin
			inflight <= inflight - 1'b1;
			wr_ptr <= wr_ptr + 1'b1;
		end
		if (pop)
			rd_ptr <= rd_ptr + 1'b1;
		case ({push, pop})
			2'b10: level <= level + 1'b1;
			2'b01: level <= level - 1'b1;
			default: level <= level;
		endcase
	end

always_ff @(posedge clkSYS) begin
	if (push)
		fifo[wr_ptr] <= rdata;
end

endmodule

/* mem_arbiter.sv */
module mem_arbiter import mem_pkg::*; (
	input logic clkSYS,
	input logic n_reset,

	input logic fr_req,
	input logic fr_wr,
	input addr_t fr_addr,
	input data_t fr_wdata,
	output logic fr_ack,
	output data_t fr_rdata,
	output logic fr_rvalid,

	input logic ts_req,
	input logic ts_wr,
	input addr_t ts_addr,
	input data_t ts_wdata,
	output logic ts_ack,
	output data_t ts_rdata,
	output logic ts_rvalid,

	output logic mem_req,
	output logic mem_wr,
	output addr_t mem_addr,
	output data_t mem_wdata,
	output id_t mem_id,
	input logic mem_ack,
	input data_t rd_data,
	input id_t rd_id,
	input logic rd_valid
);

logic ack_latch;
logic grant;

// Hold off for a cycle after the ack while the client drops its request
assign grant = !mem_req && !mem_ack && !ack_latch && (fr_req || ts_req);

always_ff @(posedge clkSYS, negedge n_reset)
	if (!n_reset) begin
		mem_req <= 1'b0;
		ack_latch <= 1'b0;
		fr_ack <= 1'b0;
		ts_ack <= 1'b0;
		fr_rvalid <= 1'b0;
		ts_rvalid <= 1'b0;
	end else begin
		ack_latch <= mem_ack;
		if (mem_ack)
			mem_req <= 1'b0;
		else if (grant)
			mem_req <= 1'b1;
		fr_ack <= mem_ack && mem_id == ID_FRAME;
		ts_ack <= mem_ack && mem_id == ID_TEST;
		fr_rvalid <= rd_valid && rd_id == ID_FRAME;
		ts_rvalid <= rd_valid && rd_id == ID_TEST;
	end

always_ff @(posedge clkSYS) begin
	if (grant) begin
		// Frame reader first
		if (fr_req) begin
			mem_wr <= fr_wr;
			mem_addr <= fr_addr;
			mem_wdata <= fr_wdata;
			mem_id <= ID_FRAME;
		end else begin
			mem_wr <= ts_wr;
			mem_addr <= ts_addr;
			mem_wdata <= ts_wdata;
			mem_id <= ID_TEST;
		end
	end
	fr_rdata <= rd_data;
	ts_rdata <= rd_data;
end

endmodule

/* burst_mem.sv */
module burst_mem import mem_pkg::*; (
	input logic clkSYS,
	input logic n_reset,
	input logic mem_req,
	input logic mem_wr,
	input addr_t mem_addr,
	input data_t mem_wdata,
	input id_t mem_id,
	output logic mem_ack,
	output data_t rd_data,
	output id_t rd_id,
	output logic rd_valid
);

data_t array [0:(1 << AN) - 1];
addr_t burst_addr;
logic [BURST_CW - 1:0] cnt;
logic take;
logic play;

// One request at a time, none while a burst is pending
assign take = mem_req && !mem_ack && cnt == '0;

// Counter runs BURST + 1 down to 1, data on the last BURST counts
assign play = cnt != '0 && cnt <= BURST_CW'(BURST);

always_ff @(posedge clkSYS, negedge n_reset)
	if (!n_reset) begin
		mem_ack <= 1'b0;
		rd_valid <= 1'b0;
		cnt <= '0;
	end else begin
		mem_ack <= take;
		rd_valid <= play;
		if (take && !mem_wr)
			cnt <= BURST_CW'(BURST + 1);
		else if (cnt != '0)
			cnt <= cnt - 1'b1;
	end

// Single word write at the ack
always_ff @(posedge clkSYS) begin
	if (take && mem_wr)
		array[mem_addr] <= mem_wdata;
end

// Burst address and tag, address wraps with the array
always_ff @(posedge clkSYS) begin
	if (take && !mem_wr) begin
		burst_addr <= mem_addr;
		rd_id <= mem_id;
	end else if (play) begin
		burst_addr <= burst_addr + 1'b1;
	end
end

always_ff @(posedge clkSYS) begin
	rd_data <= array[burst_addr];
end

endmodule

/* mem_pkg.sv */
package mem_pkg;

// Memory geometry
localparam int AN = 10;
localparam int DN = 16;
localparam int BURST = 8;
// Burst counter also covers the lead cycles
localparam int BURST_CW = $clog2(BURST + 2);

typedef logic [AN - 1:0] addr_t;
typedef logic [DN - 1:0] data_t;
typedef logic [1:0] id_t;

// Client ids
localparam id_t ID_FRAME = 2'd2;
localparam id_t ID_TEST = 2'd3;

// Frame region and pixel FIFO
localparam addr_t FRAME_BASE = '0;
localparam int FRAME_WORDS = 64;
localparam int FIFO_AW = 4;
localparam int FIFO_DEPTH = 1 << FIFO_AW;

// Tester region overlaps the frame
localparam addr_t TEST_BASE = '0;
localparam int TEST_WORDS = 64;
localparam logic [15:0] PATTERN_KEY = 16'h5a3c;

endpackage
